// ==== sim.f ====
src/dcfifo_pkg.sv
src/gray_sync.sv
src/dcfifo_mem.sv
src/dcfifo_ptr_ctrl.sv
src/dcfifo_out_stage.sv
src/dcfifo_in_csr.sv
src/dcfifo_top.sv
verif/tb_dcfifo.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the dual-clock FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_dcfifo -o tb_dcfifo_sim
./obj_dir/tb_dcfifo_sim 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation ended without a result line, see sim.log"
    exit 1
fi
echo "Simulation passed"

// ==== verif/tb_dcfifo.sv ====
/*
 * Testbench for the dual-clock packet FIFO: clocks and resets, packet table,
 * random handshakes, scoreboard queue, CSR access and compare tasks
 */

`timescale 1ns/1ps
`default_nettype none

module tb_dcfifo
    import dcfifo_pkg::*;
();

    localparam int NUM_PKTS     = 6;
    localparam int NUM_BEATS    = 30;
    localparam int WAIT_LIMIT   = 400;
    localparam int STALL_CYCLES = 20;
    localparam int SETTLE       = 16;

    logic                      in_clk = 1'b0;
    logic                      out_clk = 1'b0;
    logic                      in_reset_n;
    logic                      out_reset_n;
    beat_t                     in_beat;
    logic                      in_valid;
    logic                      in_ready;
    beat_t                     out_beat;
    logic                      out_valid;
    logic                      out_ready = 1'b0;
    csr_req_t                  in_csr;
    logic [CSR_DATA_WIDTH-1:0] in_csr_readdata;
    logic                      almost_full_valid;
    logic                      almost_full_data;

    // Packet lengths of the stimulus table, 30 beats in all
    int    pkt_len [NUM_PKTS] = '{1, 4, 7, 2, 11, 5};
    beat_t beat_table [NUM_BEATS];
    beat_t expected_q [$];

    int    in_seed  = 32'h6e65;
    int    out_seed = 32'h6e65;
    logic  hold_ready = 1'b1;
    logic  rand_ready = 1'b0;
    int    value_errors   = 0;
    int    timeout_errors = 0;

    always #20 in_clk = ~in_clk;
    always #28 out_clk = ~out_clk;

    dcfifo_top DUT (
        .in_clk            (in_clk),
        .in_reset_n        (in_reset_n),
        .out_clk           (out_clk),
        .out_reset_n       (out_reset_n),
        .in_beat           (in_beat),
        .in_valid          (in_valid),
        .in_ready          (in_ready),
        .out_beat          (out_beat),
        .out_valid         (out_valid),
        .out_ready         (out_ready),
        .in_csr            (in_csr),
        .in_csr_readdata   (in_csr_readdata),
        .almost_full_valid (almost_full_valid),
        .almost_full_data  (almost_full_data)
    );

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_beat(input beat_t got, input beat_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s got sop=%b eop=%b data=%h, expected sop=%b eop=%b data=%h",
                     $time, what, got.sop, got.eop, got.data, exp.sop, exp.eop, exp.data);
        end
    endtask

    task automatic check_word(input logic [CSR_DATA_WIDTH-1:0] got,
                              input logic [CSR_DATA_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------------
    // Sink side of the DUT output, also the scoreboard
    // ------------------------------------------------------------------
    always @(negedge out_clk) begin
        if (hold_ready) begin
            out_ready = 1'b0;
        end else if (rand_ready) begin
            out_ready = ($random(out_seed) & 32'h3) != 0;
        end else begin
            out_ready = 1'b1;
        end
        // Both stable until the next rising edge, which takes the beat
        if (out_valid === 1'b1 && out_ready) begin
            if (expected_q.size() == 0) begin
                value_errors++;
                $display("** Error at %0t: beat delivered with none expected", $time);
            end else begin
                check_beat(out_beat, expected_q.pop_front(), "out_beat");
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------
    task automatic send_beat(input beat_t b);
        int   waited;
        logic sent;
        waited = 0;
        sent   = 1'b0;
        while (!sent && waited < WAIT_LIMIT) begin
            @(negedge in_clk);
            in_beat  = b;
            in_valid = ($random(in_seed) & 32'h3) != 0;
            if (in_valid && in_ready) begin
                expected_q.push_back(b);
                sent = 1'b1;
            end
            waited++;
        end
        if (!sent) begin
            timeout_errors++;
            $display("Timeout at %0t: the FIFO never accepted a beat", $time);
        end
    endtask

    // Offers beats until in_ready has stayed low for STALL_CYCLES
    task automatic fill_until_stalled(output int accepted);
        int idle;
        int waited;
        accepted = 0;
        idle     = 0;
        waited   = 0;
        while (idle < STALL_CYCLES && waited < WAIT_LIMIT) begin
            @(negedge in_clk);
            in_beat  = '{sop: accepted == 0, eop: accepted == DEPTH, data: 8'(8'hc0 + accepted)};
            in_valid = 1'b1;
            if (in_ready) begin
                expected_q.push_back(in_beat);
                accepted++;
                idle = 0;
            end else begin
                idle++;
            end
            waited++;
        end
        in_valid = 1'b0;
        if (idle < STALL_CYCLES) begin
            timeout_errors++;
            $display("Timeout at %0t: in_ready never stayed low while filling", $time);
        end
    endtask

    task automatic wait_drained(input string what);
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge in_clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            timeout_errors++;
            $display("Timeout at %0t: %0d beats still missing after %s",
                     $time, expected_q.size(), what);
        end
    endtask

    task automatic csr_write(input logic addr, input logic [CSR_DATA_WIDTH-1:0] wdata);
        @(negedge in_clk);
        in_csr           = '0;
        in_csr.address   = addr;
        in_csr.write     = 1'b1;
        in_csr.writedata = wdata;
        @(negedge in_clk);
        in_csr = '0;
    endtask

    // Read data is ready one in_clk after the request
    task automatic csr_read(input logic addr, input logic [CSR_DATA_WIDTH-1:0] exp,
                            input string what);
        @(negedge in_clk);
        in_csr         = '0;
        in_csr.address = addr;
        in_csr.read    = 1'b1;
        @(negedge in_clk);
        in_csr = '0;
        check_word(in_csr_readdata, exp, what);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int n;
        int accepted;
        in_reset_n  = 1'b0;
        out_reset_n = 1'b0;
        in_beat     = '0;
        in_valid    = 1'b0;
        in_csr      = '0;

        n = 0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            for (int k = 0; k < pkt_len[p]; k++) begin
                beat_table[n] = '{sop: k == 0, eop: k == pkt_len[p] - 1, data: 8'(n * 37 + 11)};
                n++;
            end
        end

        fork
            begin
                repeat (2) @(negedge in_clk);
                in_reset_n = 1'b1;
                check_flag(in_ready, 1'b1, "in_ready after reset");
                check_flag(almost_full_valid, 1'b0, "almost_full_valid after reset");
                check_flag(almost_full_data, 1'b0, "almost_full_data after reset");
            end
            begin
                repeat (2) @(negedge out_clk);
                out_reset_n = 1'b1;
            end
        join
        check_flag(out_valid, 1'b0, "out_valid after reset");
        csr_read(CSR_ADDR_THRESH, '0, "threshold after reset");

        // Packets with random gaps on both sides
        hold_ready = 1'b0;
        rand_ready = 1'b1;
        for (int i = 0; i < NUM_BEATS; i++) begin
            send_beat(beat_table[i]);
        end
        @(negedge in_clk);
        in_valid = 1'b0;
        wait_drained("packet stream");

        csr_write(CSR_ADDR_THRESH, 32'ha55ac33c);
        csr_read(CSR_ADDR_THRESH, 32'h005ac33c, "threshold readback");

        // Capacity with the sink stalled
        hold_ready = 1'b1;
        repeat (3) @(negedge out_clk);
        fill_until_stalled(accepted);
        check_word(32'(accepted), 32'(DEPTH + 1), "beats accepted while stalled");
        csr_read(CSR_ADDR_FILL, 32'(DEPTH), "fill level when full");
        csr_write(CSR_ADDR_THRESH, 32'(DEPTH));
        repeat (2) @(negedge in_clk);
        check_flag(almost_full_valid, 1'b1, "almost_full_valid");
        check_flag(almost_full_data, 1'b1, "almost_full_data at DEPTH");
        csr_write(CSR_ADDR_THRESH, 32'(DEPTH + 1));
        repeat (2) @(negedge in_clk);
        check_flag(almost_full_data, 1'b0, "almost_full_data at DEPTH+1");

        // Drain and let the read pointer cross back
        hold_ready = 1'b0;
        rand_ready = 1'b0;
        wait_drained("capacity drain");
        repeat (SETTLE) @(negedge in_clk);
        check_flag(out_valid, 1'b0, "out_valid after drain");
        csr_read(CSR_ADDR_FILL, '0, "fill level after drain");
        csr_write(CSR_ADDR_THRESH, 32'd1);
        repeat (2) @(negedge in_clk);
        check_flag(almost_full_data, 1'b0, "almost_full_data after drain");

        $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/dcfifo_top.sv ====
/*
 * Dual-clock packet FIFO top level, connects pointer control,
 * memory, output stage and input CSR
 */

`timescale 1ns/1ps
`default_nettype none

module dcfifo_top
    import dcfifo_pkg::*;
(
    input  wire logic                      in_clk,
    input  wire logic                      in_reset_n,
    input  wire logic                      out_clk,
    input  wire logic                      out_reset_n,

    // Sink
    input  wire beat_t                     in_beat,
    input  wire logic                      in_valid,
    output logic                           in_ready,

    // Source
    output beat_t                          out_beat,
    output logic                           out_valid,
    input  wire logic                      out_ready,

    // Input CSR and status
    input  wire csr_req_t                  in_csr,
    output logic      [CSR_DATA_WIDTH-1:0] in_csr_readdata,
    output logic                           almost_full_valid,
    output logic                           almost_full_data
);

    logic  wr_en;
    addr_t wr_addr;
    addr_t rd_addr;
    beat_t rd_beat;
    logic  stage_ready;
    logic  mem_valid;
    ptr_t  wr_ptr_next;
    ptr_t  rd_ptr_sync_bin;

    dcfifo_ptr_ctrl u_ptr_ctrl (
        .in_clk          (in_clk),
        .in_reset_n      (in_reset_n),
        .out_clk         (out_clk),
        .out_reset_n     (out_reset_n),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .stage_ready     (stage_ready),
        .mem_valid       (mem_valid),
        .rd_addr         (rd_addr),
        .wr_ptr_next     (wr_ptr_next),
        .rd_ptr_sync_bin (rd_ptr_sync_bin)
    );

    dcfifo_mem u_mem (
        .in_clk  (in_clk),
        .out_clk (out_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_beat (in_beat),
        .rd_addr (rd_addr),
        .rd_beat (rd_beat)
    );

    dcfifo_out_stage u_out_stage (
        .out_clk     (out_clk),
        .out_reset_n (out_reset_n),
        .mem_valid   (mem_valid),
        .rd_beat     (rd_beat),
        .out_ready   (out_ready),
        .stage_ready (stage_ready),
        .out_beat    (out_beat),
        .out_valid   (out_valid)
    );

    dcfifo_in_csr u_in_csr (
        .in_clk            (in_clk),
        .in_reset_n        (in_reset_n),
        .wr_ptr_next       (wr_ptr_next),
        .rd_ptr_sync_bin   (rd_ptr_sync_bin),
        .in_csr            (in_csr),
        .in_csr_readdata   (in_csr_readdata),
        .almost_full_valid (almost_full_valid),
        .almost_full_data  (almost_full_data)
    );

endmodule

`default_nettype wire

// ==== src/dcfifo_in_csr.sv ====
/*
 * Input fill level, almost-full threshold register, CSR access
 * and the streaming almost-full status
 */

`timescale 1ns/1ps
`default_nettype none

module dcfifo_in_csr
    import dcfifo_pkg::*;
(
    input  wire logic                      in_clk,
    input  wire logic                      in_reset_n,
    input  wire ptr_t                      wr_ptr_next,
    input  wire ptr_t                      rd_ptr_sync_bin,
    input  wire csr_req_t                  in_csr,
    output logic      [CSR_DATA_WIDTH-1:0] in_csr_readdata,
    output logic                           almost_full_valid,
    output logic                           almost_full_data
);

    ptr_t    fill_level;
    thresh_t threshold;

    // Memory occupancy only, the output register is not counted
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            fill_level <= '0;
        end else begin
            fill_level <= wr_ptr_next - rd_ptr_sync_bin;
        end
    end

    // ------------------------------------------------------------------
    // CSR port, write wins over read
    // ------------------------------------------------------------------
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            threshold       <= '0;
            in_csr_readdata <= '0;
        end else if (in_csr.write) begin
            if (in_csr.address == CSR_ADDR_THRESH) begin
                threshold <= in_csr.writedata[CSR_FIELD_WIDTH-1:0];
            end
        end else if (in_csr.read) begin
            if (in_csr.address == CSR_ADDR_FILL) begin
                in_csr_readdata <= {{(CSR_DATA_WIDTH - ADDR_WIDTH - 1){1'b0}}, fill_level};
            end else begin
                in_csr_readdata <= {{(CSR_DATA_WIDTH - CSR_FIELD_WIDTH){1'b0}}, threshold};
            end
        end
    end

    // ------------------------------------------------------------------
    // Almost-full status
    // ------------------------------------------------------------------
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            almost_full_valid <= 1'b0;
            almost_full_data  <= 1'b0;
        end else begin
            almost_full_valid <= 1'b1;
            almost_full_data  <=
                ({{(CSR_FIELD_WIDTH - ADDR_WIDTH - 1){1'b0}}, fill_level} >= threshold);
        end
    end

endmodule

`default_nettype wire

// ==== src/dcfifo_out_stage.sv ====
/*
 * Output register stage on out_clk that holds its beat while stalled
 */

`timescale 1ns/1ps
`default_nettype none

module dcfifo_out_stage
    import dcfifo_pkg::*;
(
    input  wire logic  out_clk,
    input  wire logic  out_reset_n,
    input  wire logic  mem_valid,
    input  wire beat_t rd_beat,
    input  wire logic  out_ready,
    output logic       stage_ready,
    output beat_t      out_beat,
    output logic       out_valid
);

    // Register can take a new beat when empty or being drained
    assign stage_ready = out_ready || !out_valid;

    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            out_valid <= 1'b0;
        end else if (stage_ready) begin
            out_valid <= mem_valid;
        end
    end

    always_ff @(posedge out_clk) begin
        if (stage_ready) begin
            out_beat <= rd_beat;
        end
    end

    // Head beat stays offered while the stage is stalled
    a_head_kept: assert property (
        @(posedge out_clk) disable iff (!out_reset_n)
        (mem_valid && !stage_ready) |=> mem_valid
    ) else $error("FIFO went empty without a pop");

endmodule

`default_nettype wire

// ==== src/dcfifo_ptr_ctrl.sv ====
/*
 * Write and read pointers in their own clocks, full and empty flags,
 * and Gray crossing of both pointers
 */

`timescale 1ns/1ps
`default_nettype none

module dcfifo_ptr_ctrl
    import dcfifo_pkg::*;
(
    input  wire logic in_clk,
    input  wire logic in_reset_n,
    input  wire logic out_clk,
    input  wire logic out_reset_n,
    input  wire logic in_valid,
    output logic      in_ready,
    output logic      wr_en,
    output addr_t     wr_addr,
    input  wire logic stage_ready,
    output logic      mem_valid,
    output addr_t     rd_addr,
    output ptr_t      wr_ptr_next,
    output ptr_t      rd_ptr_sync_bin
);

    ptr_t wr_ptr;
    ptr_t wr_ptr_gray;
    ptr_t rd_ptr;
    ptr_t rd_ptr_next;
    ptr_t rd_ptr_gray;
    ptr_t rd_ptr_gray_sync;
    ptr_t wr_ptr_gray_sync;
    ptr_t wr_ptr_sync_bin;
    logic full;
    logic empty;
    logic pop;

    // ------------------------------------------------------------------
    // Write side, in_clk
    // ------------------------------------------------------------------
    assign in_ready    = !full;
    assign wr_en       = in_valid && in_ready;
    assign wr_addr     = wr_ptr[ADDR_WIDTH-1:0];
    assign wr_ptr_next = wr_en ? wr_ptr + 1'b1 : wr_ptr;

    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            wr_ptr      <= '0;
            wr_ptr_gray <= '0;
            full        <= 1'b0;
        end else begin
            wr_ptr      <= wr_ptr_next;
            wr_ptr_gray <= bin2gray(wr_ptr);
            // Same slot, opposite wrap bit
            full        <= (wr_ptr_next[ADDR_WIDTH-1:0] == rd_ptr_sync_bin[ADDR_WIDTH-1:0]) &&
                           (wr_ptr_next[ADDR_WIDTH] != rd_ptr_sync_bin[ADDR_WIDTH]);
        end
    end

    // ------------------------------------------------------------------
    // Read side, out_clk
    // ------------------------------------------------------------------
    assign pop         = stage_ready && !empty;
    assign rd_ptr_next = pop ? rd_ptr + 1'b1 : rd_ptr;
    assign rd_addr     = rd_ptr_next[ADDR_WIDTH-1:0];
    assign mem_valid   = !empty;

    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
            empty       <= 1'b1;
        end else begin
            rd_ptr      <= rd_ptr_next;
            rd_ptr_gray <= bin2gray(rd_ptr);
            empty       <= (rd_ptr_next == wr_ptr_sync_bin);
        end
    end

    // ------------------------------------------------------------------
    // Pointer crossing
    // ------------------------------------------------------------------
    gray_sync #(.WIDTH(ADDR_WIDTH + 1), .STAGES(SYNC_DEPTH)) u_wr_crosser (
        .clk     (out_clk),
        .reset_n (out_reset_n),
        .din     (wr_ptr_gray),
        .dout    (wr_ptr_gray_sync)
    );

    gray_sync #(.WIDTH(ADDR_WIDTH + 1), .STAGES(SYNC_DEPTH)) u_rd_crosser (
        .clk     (in_clk),
        .reset_n (in_reset_n),
        .din     (rd_ptr_gray),
        .dout    (rd_ptr_gray_sync)
    );

    assign wr_ptr_sync_bin = gray2bin(wr_ptr_gray_sync);
    assign rd_ptr_sync_bin = gray2bin(rd_ptr_gray_sync);

    // Write side never runs more than DEPTH ahead of the synced read pointer
    a_no_overfill: assert property (
        @(posedge in_clk) disable iff (!in_reset_n)
        ptr_t'(wr_ptr - rd_ptr_sync_bin) <= ptr_t'(DEPTH)
    ) else $error("write pointer ran past a full FIFO");

endmodule

`default_nettype wire

// ==== src/dcfifo_mem.sv ====
/*
 * Payload memory, written on in_clk and read through a register on out_clk
 */

`timescale 1ns/1ps
`default_nettype none

module dcfifo_mem
    import dcfifo_pkg::*;
(
    input  wire logic  in_clk,
    input  wire logic  out_clk,
    input  wire logic  wr_en,
    input  wire addr_t wr_addr,
    input  wire beat_t wr_beat,
    input  wire addr_t rd_addr,
    output beat_t      rd_beat
);

    beat_t mem [DEPTH];

    always_ff @(posedge in_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // Read word is registered every cycle, the address is the next head
    always_ff @(posedge out_clk) begin
        rd_beat <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== src/gray_sync.sv ====
/*
 * Flop chain that carries a Gray-coded pointer into another clock
 */

`timescale 1ns/1ps
`default_nettype none

module gray_sync #(
    parameter int WIDTH  = 5,
    parameter int STAGES = 2
) (
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic [WIDTH-1:0] din,
    output logic      [WIDTH-1:0] dout
);

    // Stage 0 samples the foreign-clock word, the last stage is used
    logic [STAGES-1:0][WIDTH-1:0] sync_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[STAGES-2:0], din};
        end
    end

    assign dout = sync_q[STAGES-1];

endmodule

`default_nettype wire

// ==== src/dcfifo_pkg.sv ====
/*
 * Shared widths, CSR address map, beat and CSR request types,
 * and binary/Gray conversion for the dual-clock FIFO pointers
 */

`default_nettype none

package dcfifo_pkg;

    localparam int DATA_WIDTH      = 8;
    localparam int ADDR_WIDTH      = 4;
    localparam int DEPTH           = 16;
    localparam int SYNC_DEPTH      = 2;
    localparam int CSR_DATA_WIDTH  = 32;
    localparam int CSR_FIELD_WIDTH = 24;
    localparam bit CSR_ADDR_FILL   = 1'b0;
    localparam bit CSR_ADDR_THRESH = 1'b1;

    // Pointers carry one extra wrap bit to tell full from empty
    typedef logic [ADDR_WIDTH:0]      ptr_t;
    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [CSR_FIELD_WIDTH-1:0] thresh_t;

    typedef struct packed {
        logic                  sop;
        logic                  eop;
        logic [DATA_WIDTH-1:0] data;
    } beat_t;

    typedef struct packed {
        logic                      address;
        logic                      read;
        logic                      write;
        logic [CSR_DATA_WIDTH-1:0] writedata;
    } csr_req_t;

    function automatic ptr_t bin2gray(input ptr_t bin_val);
        return bin_val ^ (bin_val >> 1);
    endfunction

    // Each binary bit is the XOR of all Gray bits at or above it
    function automatic ptr_t gray2bin(input ptr_t gray_val);
        ptr_t bin_val;
        bin_val[ADDR_WIDTH] = gray_val[ADDR_WIDTH];
        for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
            bin_val[i] = bin_val[i+1] ^ gray_val[i];
        end
        return bin_val;
    endfunction

endpackage

`default_nettype wire
